// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_nbus_system
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/acc_cpu.sv
`timescale 1ns/1ps

module acc_cpu #(
  parameter nbus_pkg::addr_t reset_vector = '0
) (
  input  logic              clk,
  input  logic              reset,
  output nbus_pkg::wb_req_t wb_req,
  input  logic              wb_ack,
  input  nbus_pkg::word_t   wb_dat,
  output logic              halted
);

  typedef enum logic [2:0] {
    fetch,       // Put the instruction read on the bus
    fetch_wait,  // Wait for the instruction word
    exec,        // Decode and either finish or start a data access
    mem_wait,    // Wait for the data access of load, add or store
    halt_st      // Parked until reset
  } state_e;

  state_e            state;
  nbus_pkg::addr_t   pc;
  nbus_pkg::word_t   acc;
  nbus_pkg::word_t   ir;            // Current instruction
  nbus_pkg::opcode_e opcode;
  logic [23:0]       operand;
  nbus_pkg::addr_t   operand_adr;   // Operand taken as a word address
  nbus_pkg::word_t   operand_sext;  // Operand taken as a signed immediate
  nbus_pkg::addr_t   pc_next;

  assign opcode       = nbus_pkg::opcode_e'(ir[31:24]);
  assign operand      = ir[23:0];
  assign operand_adr  = {6'b0, operand, 2'b00};
  assign operand_sext = {{8{operand[23]}}, operand};
  assign pc_next      = pc + 32'd4;

  assign halted = (state == halt_st);

  // Instruction register loads on the fetch ack
  always_ff @(posedge clk) begin
    if (state == fetch_wait && wb_ack) begin
      ir <= wb_dat;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= fetch;
      pc     <= reset_vector;
      acc    <= '0;
      wb_req <= '0;
    end else begin
      case (state)
        fetch: begin
          wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: pc, dat: '0};
          state  <= fetch_wait;
        end

        fetch_wait: begin
          if (wb_ack) begin
            wb_req.cyc <= 1'b0;  // End of cycle, nothing new this clock
            wb_req.stb <= 1'b0;
            state      <= exec;
          end
        end

        exec: begin
          case (opcode)
            nbus_pkg::op_load, nbus_pkg::op_add: begin
              wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: operand_adr, dat: '0};
              state  <= mem_wait;
            end
            nbus_pkg::op_store: begin
              wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: operand_adr, dat: acc};
              state  <= mem_wait;
            end
            nbus_pkg::op_addi: begin
              acc   <= acc + operand_sext;
              pc    <= pc_next;
              state <= fetch;
            end
            nbus_pkg::op_jmp: begin
              pc    <= operand_adr;  // Target given as a word address
              state <= fetch;
            end
            nbus_pkg::op_jz: begin
              pc    <= (acc == '0) ? operand_adr : pc_next;
              state <= fetch;
            end
            nbus_pkg::op_halt: begin
              state <= halt_st;
            end
            default: begin
              state <= halt_st;  // Unknown opcode stops the machine
            end
          endcase
        end

        mem_wait: begin
          if (wb_ack) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            if (opcode == nbus_pkg::op_load) begin
              acc <= wb_dat;
            end else if (opcode == nbus_pkg::op_add) begin
              acc <= acc + wb_dat;
            end
            pc    <= pc_next;  // Store needs no register update
            state <= fetch;
          end
        end

        halt_st: begin
          state <= halt_st;
        end

        default: begin
          state <= fetch;
        end
      endcase
    end
  end

  // Classic handshake, the master may not change a pending request
  a_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    (wb_req.stb && !wb_ack) |=> $stable(wb_req)
  );

  // A halted core leaves the bus quiet
  a_no_stb_halted: assert property (
    @(posedge clk) disable iff (reset)
    (state == halt_st) |-> !wb_req.stb
  );

endmodule

// File: source/nbus_bridge.sv
`timescale 1ns/1ps

module nbus_bridge (
  input  logic                clk,
  input  logic                reset,
  input  nbus_pkg::wb_req_t   wb_req,
  output logic                wb_ack,
  output nbus_pkg::word_t     wb_dat,
  output logic                frame_start,
  output nbus_pkg::pin_byte_t addr_pins,
  output nbus_pkg::pin_byte_t data_out,
  input  nbus_pkg::pin_byte_t data_in,
  output logic                data_oe
);

  typedef logic [3:0] beat_t;

  localparam beat_t last_beat = beat_t'(nbus_pkg::frame_beats);
  localparam beat_t cmd_beat  = beat_t'(nbus_pkg::cmd_beat);

  beat_t               beat;       // 0 when idle, 1 to 9 inside a frame
  beat_t               next_beat;
  logic                start;
  nbus_pkg::wb_req_t   req_q;      // Request held for the whole frame
  nbus_pkg::wb_req_t   cur_req;
  logic [1:0]          lane;       // Byte lane for the coming beat
  nbus_pkg::pin_byte_t adr_byte;
  nbus_pkg::pin_byte_t wr_byte;
  nbus_pkg::word_t     rd_shift;   // Read bytes enter from the top

  // New frame only from idle and not in the ack cycle
  assign start = (beat == '0) && !wb_ack && wb_req.cyc && wb_req.stb;

  always_comb begin
    next_beat = '0;
    if (start) begin
      next_beat = beat_t'(1);
    end else if (beat != '0 && beat != last_beat) begin
      next_beat = beat + beat_t'(1);
    end
  end

  // On the start edge the latch is not loaded yet
  assign cur_req = start ? wb_req : req_q;

  always_comb begin
    if (next_beat > cmd_beat) begin
      lane = 2'(next_beat - cmd_beat - beat_t'(1));  // Beats 6-9
    end else begin
      lane = 2'(next_beat - beat_t'(1));  // Beats 1-4
    end
  end

  assign adr_byte = cur_req.adr[8*lane +: 8];
  assign wr_byte  = cur_req.we ? cur_req.dat[8*lane +: 8] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      beat        <= '0;
      wb_ack      <= 1'b0;
      frame_start <= 1'b0;
      data_oe     <= 1'b0;
    end else begin
      beat        <= next_beat;
      wb_ack      <= (beat == last_beat);  // One cycle after beat 9
      frame_start <= start;
      data_oe     <= (next_beat != '0) && (next_beat != cmd_beat) && cur_req.we;
    end
  end

  // Pin lanes are registered from the beat about to begin
  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= wb_req;
    end
    case (next_beat)
      beat_t'(1), beat_t'(2), beat_t'(3), beat_t'(4): begin
        addr_pins <= adr_byte;  // Address, low byte first
        data_out  <= wr_byte;
      end
      cmd_beat: begin
        addr_pins <= {7'b0, cur_req.we};  // Write flag on bit 0
        data_out  <= '0;
      end
      beat_t'(6), beat_t'(7), beat_t'(8), beat_t'(9): begin
        addr_pins <= '0;
        data_out  <= wr_byte;
      end
      default: begin
        addr_pins <= '0;
        data_out  <= '0;
      end
    endcase
  end

  // Sample data_in at the end of each data beat of a read
  always_ff @(posedge clk) begin
    if (beat > cmd_beat && !req_q.we) begin
      rd_shift <= {data_in, rd_shift[31:8]};
    end
  end

  assign wb_dat = rd_shift;

  a_ack_single: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack
  );

  // Frames do not overlap on the pins
  a_frame_spacing: assert property (
    @(posedge clk) disable iff (reset)
    frame_start |=> !frame_start [*8]
  );

endmodule

// File: source/nbus_pkg.sv
package nbus_pkg;

  // Data and address widths on the processor side
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // One byte on the narrow pin port
  typedef logic [7:0] pin_byte_t;

  // Opcode lives in the top byte of an instruction word
  // The low 24 bits hold a word address or a signed immediate
  typedef enum logic [7:0] {
    op_load  = 8'h01,  // acc = mem[operand*4]
    op_store = 8'h02,  // mem[operand*4] = acc
    op_add   = 8'h03,  // acc = acc + mem[operand*4]
    op_addi  = 8'h04,  // acc = acc + sext(operand)
    op_jmp   = 8'h05,  // pc = operand*4
    op_jz    = 8'h06,  // pc = operand*4 when acc is zero
    op_halt  = 8'h07   // Stop fetching
  } opcode_e;

  // Wishbone classic master request, 67 bits
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat;
  } wb_req_t;

  // Pin frame layout
  // Beats 1-4 address bytes, beat 5 command, beats 6-9 data bytes
  localparam int frame_beats = 9;
  localparam int cmd_beat    = 5;

endpackage

// File: source/nbus_system.sv
`timescale 1ns/1ps

module nbus_system #(
  parameter nbus_pkg::addr_t reset_vector = '0
) (
  input  logic                clk,
  input  logic                reset,
  output logic                frame_start,
  output nbus_pkg::pin_byte_t addr_pins,
  output nbus_pkg::pin_byte_t data_out,
  input  nbus_pkg::pin_byte_t data_in,
  output logic                data_oe,
  output logic                halted
);

  // Wishbone link between core and bridge
  nbus_pkg::wb_req_t wb_req;
  logic              wb_ack;
  nbus_pkg::word_t   wb_dat;

  acc_cpu #(
    .reset_vector(reset_vector)
  ) cpu_i (
    .clk   (clk),
    .reset (reset),
    .wb_req(wb_req),
    .wb_ack(wb_ack),
    .wb_dat(wb_dat),
    .halted(halted)
  );

  nbus_bridge bridge_i (
    .clk        (clk),
    .reset      (reset),
    .wb_req     (wb_req),
    .wb_ack     (wb_ack),
    .wb_dat     (wb_dat),
    .frame_start(frame_start),
    .addr_pins  (addr_pins),
    .data_out   (data_out),
    .data_in    (data_in),
    .data_oe    (data_oe)
  );

endmodule

// File: tb.f
source/nbus_pkg.sv
source/acc_cpu.sv
source/nbus_bridge.sv
source/nbus_system.sv
testbench/tb_clock.sv
testbench/ext_mem_model.sv
testbench/tb_nbus_system.sv

// File: testbench/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,         // Copy image into the byte array
  input  nbus_pkg::word_t     image [64],
  input  logic                frame_start,
  input  nbus_pkg::pin_byte_t addr_pins,
  input  nbus_pkg::pin_byte_t data_out,
  output nbus_pkg::pin_byte_t data_in,
  output logic                frame_done,   // One cycle, after beat 9
  output nbus_pkg::addr_t     frame_adr,
  output logic                frame_we,
  output nbus_pkg::word_t     frame_dat,
  output nbus_pkg::addr_t     last_wr_adr,
  output nbus_pkg::word_t     last_wr_dat,
  output int unsigned         frame_count
);

  nbus_pkg::pin_byte_t mem [256];
  logic [3:0]          beat;       // Beats 2-9 of the running frame, else 0
  logic [3:0]          cur;        // Beat on the pins this cycle
  logic [1:0]          lane;
  logic [7:0]          idx;
  nbus_pkg::addr_t     adr;
  logic                we;
  nbus_pkg::word_t     dat;
  nbus_pkg::pin_byte_t beat_byte;  // Data byte moving in this beat

  assign cur       = frame_start ? 4'd1 : beat;
  assign lane      = (cur > 4'd5) ? 2'(cur - 4'd6) : 2'(cur - 4'd1);
  assign idx       = adr[7:0] + {6'b0, lane};
  assign beat_byte = we ? data_out : data_in;

  // Read data goes out in beats 6-9, little-endian
  always_comb begin
    data_in = '0;
    if (cur > 4'd5 && !we) begin
      data_in = mem[idx];
    end
  end

  always @(posedge clk) begin
    frame_done <= 1'b0;
    if (load) begin
      for (int i = 0; i < 64; i++) begin
        for (int b = 0; b < 4; b++) begin
          mem[4 * i + b] <= image[i][8 * b +: 8];
        end
      end
    end
    if (reset) begin
      beat        <= '0;
      we          <= 1'b0;
      last_wr_adr <= '0;
      last_wr_dat <= '0;
      frame_count <= 0;
    end else begin
      beat <= (cur == 4'd0 || cur == 4'd9) ? 4'd0 : cur + 4'd1;
      if (cur >= 4'd1 && cur <= 4'd4) begin
        adr[{lane, 3'b000} +: 8] <= addr_pins;  // Address, low byte first
      end else if (cur == 4'd5) begin
        we <= addr_pins[0];  // Command beat
      end else if (cur > 4'd5) begin
        dat[{lane, 3'b000} +: 8] <= beat_byte;
        if (we) begin
          mem[idx] <= data_out;
        end
      end
      if (cur == 4'd9) begin
        frame_done  <= 1'b1;
        frame_adr   <= adr;
        frame_we    <= we;
        frame_dat   <= {beat_byte, dat[23:0]};
        frame_count <= frame_count + 1;
        if (we) begin
          last_wr_adr <= adr;
          last_wr_dat <= {beat_byte, dat[23:0]};
        end
      end
    end
  end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real period_ns = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;  // Free running, even duty
  end

endmodule

// File: testbench/tb_nbus_system.sv
`timescale 1ns/1ps

module tb_nbus_system;

  localparam int a_word = 16;
  localparam int b_word = 17;
  localparam int s_word = 18;  // Receives A+B
  localparam int t_word = 19;  // Receives A+B+imm
  localparam logic [23:0] imm = 24'hffff9c;  // -100
  localparam nbus_pkg::addr_t s_adr = nbus_pkg::addr_t'(4 * s_word);
  localparam nbus_pkg::addr_t t_adr = nbus_pkg::addr_t'(4 * t_word);

  logic                clk;
  logic                reset;
  logic                load;
  nbus_pkg::word_t     image [64];
  logic                frame_start;
  nbus_pkg::pin_byte_t addr_pins;
  nbus_pkg::pin_byte_t data_out;
  nbus_pkg::pin_byte_t data_in;
  logic                data_oe;
  logic                halted;
  logic                frame_done;
  nbus_pkg::addr_t     frame_adr;
  logic                frame_we;
  nbus_pkg::word_t     frame_dat;
  nbus_pkg::addr_t     last_wr_adr;
  nbus_pkg::word_t     last_wr_dat;
  int unsigned         frame_count;

  logic [31:0]     lfsr = 32'h47db56a5;
  nbus_pkg::word_t op_a;
  nbus_pkg::word_t op_b;
  nbus_pkg::word_t exp_sum;
  nbus_pkg::word_t exp_t;
  nbus_pkg::addr_t adr_q [$];  // One entry per finished frame
  logic            we_q [$];
  nbus_pkg::word_t dat_q [$];
  logic [3:0]      mon_beat;
  logic [3:0]      mon_cur;
  logic            mon_we;
  int              test_errs = 0;
  int              shape_errs = 0;
  int              passed = 0;
  int              failed = 0;

  tb_clock clock_i (.clk(clk));

  nbus_system #(
    .reset_vector(32'h0)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .frame_start(frame_start),
    .addr_pins  (addr_pins),
    .data_out   (data_out),
    .data_in    (data_in),
    .data_oe    (data_oe),
    .halted     (halted)
  );

  ext_mem_model mem_i (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .image      (image),
    .frame_start(frame_start),
    .addr_pins  (addr_pins),
    .data_out   (data_out),
    .data_in    (data_in),
    .frame_done (frame_done),
    .frame_adr  (frame_adr),
    .frame_we   (frame_we),
    .frame_dat  (frame_dat),
    .last_wr_adr(last_wr_adr),
    .last_wr_dat(last_wr_dat),
    .frame_count(frame_count)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output nbus_pkg::word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  function automatic nbus_pkg::word_t encode(input nbus_pkg::opcode_e op,
                                             input logic [23:0] operand);
    return {op, operand};
  endfunction

  task automatic check_value(input string test, input nbus_pkg::word_t expected,
                             input nbus_pkg::word_t actual);
    assert (actual == expected) else begin
      $display("Error %s: expected %h, actual %h", test, expected, actual);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string test);
    if (test_errs == 0) begin
      $display("test %s passed", test);
      passed++;
    end else begin
      $display("test %s failed with %0d errors", test, test_errs);
      failed++;
    end
    test_errs = 0;
  endtask

  task automatic wait_for_store(input nbus_pkg::addr_t adr, input int limit, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < limit) begin
      @(negedge clk);
      ok = (last_wr_adr == adr) && (adr_q.size() == int'(frame_count));  // Queue caught up
      n++;
    end
  endtask

  task automatic wait_for_halt(input int limit, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < limit) begin
      @(negedge clk);
      ok = halted;
      n++;
    end
  endtask

  always @(negedge clk) begin
    if (frame_done) begin
      adr_q.push_back(frame_adr);
      we_q.push_back(frame_we);
      dat_q.push_back(frame_dat);
    end
  end

  // Frame shape on the pins
  assign mon_cur = frame_start ? 4'd1 : mon_beat;

  always @(negedge clk) begin
    if (reset) begin
      mon_beat <= '0;
    end else begin
      mon_beat <= (mon_cur == 4'd0 || mon_cur == 4'd9) ? 4'd0 : mon_cur + 4'd1;
      assert (!(frame_start && mon_beat != 4'd0)) else begin
        $display("Error frame_shape: frame_start in beat %0d of a running frame", mon_beat);
        shape_errs++;
      end
      if (mon_cur == 4'd1) begin
        mon_we <= data_oe;  // Checked against the flag in beat 5
      end else if (mon_cur == 4'd5) begin
        assert (!data_oe && addr_pins == {7'b0, mon_we}) else begin
          $display("Error frame_shape: expected command %h, actual %h, data_oe %b",
                   {7'b0, mon_we}, addr_pins, data_oe);
          shape_errs++;
        end
      end else if (mon_cur == 4'd0) begin
        assert (!data_oe) else begin
          $display("Error frame_shape: data_oe is high outside a frame");
          shape_errs++;
        end
      end else begin
        assert (data_oe == mon_we) else begin
          $display("Error frame_shape: expected data_oe %b, actual %b in beat %0d",
                   mon_we, data_oe, mon_cur);
          shape_errs++;
        end
      end
    end
  end

  initial begin
    bit              ok;
    int unsigned     count_at_halt;
    int              wr_count;
    nbus_pkg::addr_t first_wr_adr;
    nbus_pkg::word_t first_wr_dat;

    reset <= 1'b1;
    load  <= 1'b1;
    for (int i = 0; i < 64; i++) begin
      image[i] = '0;
    end
    draw_word(op_a);
    draw_word(op_b);
    exp_sum = op_a + op_b;
    exp_t   = exp_sum + {{8{imm[23]}}, imm};  // Both jz paths leave this in T

    image[0]      = encode(nbus_pkg::op_load, 24'(a_word));
    image[1]      = encode(nbus_pkg::op_add, 24'(b_word));
    image[2]      = encode(nbus_pkg::op_store, 24'(s_word));
    image[3]      = encode(nbus_pkg::op_addi, imm);
    image[4]      = encode(nbus_pkg::op_jz, 24'd7);
    image[5]      = encode(nbus_pkg::op_store, 24'(t_word));
    image[6]      = encode(nbus_pkg::op_halt, 24'd0);
    image[7]      = encode(nbus_pkg::op_store, 24'(t_word));  // Zero sum lands here
    image[8]      = encode(nbus_pkg::op_halt, 24'd0);
    image[a_word] = op_a;
    image[b_word] = op_b;

    repeat (2) @(negedge clk);
    reset <= 1'b0;
    load  <= 1'b0;

    @(negedge clk);
    check_value("reset", 32'h0, {29'b0, frame_start, data_oe, halted});
    finish_test("reset");

    wait_for_store(t_adr, 2000, ok);
    assert (ok) else begin
      $display("Timeout waiting for the store to address %h", t_adr);
      test_errs++;
    end

    // Fetches are frames 0, 2 and 4 since load and add add one access each
    assert (adr_q.size() >= 5) else begin
      $display("Only %0d frames were seen before the last store", adr_q.size());
      test_errs++;
    end
    if (adr_q.size() >= 5) begin
      for (int k = 0; k < 3; k++) begin
        check_value("read_assembly", nbus_pkg::word_t'(4 * k), adr_q[2 * k]);
        check_value("read_assembly", 32'h0, {31'b0, we_q[2 * k]});
      end
    end
    finish_test("read_assembly");

    wr_count     = 0;
    first_wr_adr = '0;
    first_wr_dat = '0;
    foreach (adr_q[i]) begin
      if (we_q[i]) begin
        if (wr_count == 0) begin
          first_wr_adr = adr_q[i];
          first_wr_dat = dat_q[i];
        end
        wr_count++;
      end
    end
    check_value("store_value", 32'd2, 32'(wr_count));
    check_value("store_value", s_adr, first_wr_adr);
    check_value("store_value", exp_sum, first_wr_dat);
    check_value("store_value", exp_t, last_wr_dat);
    finish_test("store_value");

    wait_for_halt(40, ok);
    assert (ok) else begin
      $display("Timeout waiting for halted after the last store");
      test_errs++;
    end
    count_at_halt = frame_count;
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      assert (!frame_start) else begin
        $display("A frame started %0d cycles after halt", i);
        test_errs++;
      end
    end
    check_value("halt", 32'(count_at_halt), 32'(frame_count));
    check_value("halt", 32'h1, {31'b0, halted});
    finish_test("halt");

    assert (frame_count > 0) else begin
      $display("No frame was seen on the pins");
      test_errs++;
    end
    test_errs = test_errs + shape_errs;
    finish_test("frame_shape");

    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
